/* readout_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Readout package
// Word format, data identifiers, buffer sizes and the shared types of the
// readout data path
////////////////////////////////////////////////////////////////////////////
package readout_pkg;

    localparam int WORD_W        = 32;
    localparam int FE_W          = 24;
    localparam int TDC_W         = 12;     // Width field, saturates at all ones
    localparam int TDC_CNT_W     = 16;
    localparam int SRC_N         = 3;
    localparam int SRC_DEPTH     = 8;
    localparam int OUT_DEPTH     = 32;
    localparam int NEAR_FULL_GAP = 4;      // Free slots at which near-full rises
    localparam int TRIG_BIT      = 31;

    localparam logic [3:0] TDC_ID = 4'b0100;
    localparam logic [3:0] FE_ID  = 4'b0010;

    typedef enum logic [2:0] {
        IDLE,
        WRITE_WORD,
        CMD_REQ,
        CMD_RELEASE,
        HOLD_DRAIN
    } trig_state_t;

    // Source index, doubles as the grant code
    typedef enum logic [1:0] {
        SRC_TLU = 2'd0,
        SRC_TDC = 2'd1,
        SRC_FE  = 2'd2
    } src_sel_t;

    typedef struct packed {
        logic not_empty;
        logic hold;          // Keep priority until drained
    } src_req_t;

    typedef struct packed {
        logic [3:0]           id;
        logic [TDC_CNT_W-1:0] evt_cnt;
        logic [TDC_W-1:0]     width;
    } tdc_word_t;

    typedef struct packed {
        logic [3:0]      id;
        logic [3:0]      rsvd;
        logic [FE_W-1:0] payload;
    } fe_word_t;

endpackage

/* word_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// Word FIFO
// Synchronous first-word-fall-through buffer with full and near-full flags
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module word_fifo import readout_pkg::*; #(
    parameter int DEPTH = 8
) (
    input  logic              bus_clk,
    input  logic              rst_n,
    input  logic              wr,
    input  logic [WORD_W-1:0] din,
    input  logic              rd,
    output logic [WORD_W-1:0] dout,
    output logic              empty,
    output logic              full,
    output logic              near_full
);

    logic [WORD_W-1:0]          mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] cnt;    // Words stored
    logic                       do_wr;
    logic                       do_rd;

    assign do_wr = wr && !full;     // Drop writes when full
    assign do_rd = rd && !empty;

    assign empty     = (cnt == 0);
    assign full      = (cnt == DEPTH);
    assign near_full = (cnt >= DEPTH - NEAR_FULL_GAP);
    assign dout      = mem[rd_ptr]; // Head word always visible

    always_ff @(posedge bus_clk) begin
        if (do_wr)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: ;  // Push and pop together keep the count
            endcase
        end
    end

endmodule

/* tlu_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Trigger controller
// Accepts triggers, numbers them, raises busy and starts the command
// sequencer through a four-phase handshake
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tlu_ctrl import readout_pkg::*; (
    input  logic              bus_clk,
    input  logic              rst_n,
    input  logic              trig_en,
    input  logic              trig_in,
    input  logic              veto,
    input  logic              fifo_full,
    input  logic              fifo_empty,
    output logic              wr,
    output logic [WORD_W-1:0] word,
    output logic              hold,
    output logic              busy,
    output logic              cmd_req,
    input  logic              cmd_ack
);

    trig_state_t         state;
    trig_state_t         state_nxt;
    logic [1:0]          trig_sync;     // Two-flop synchronizer
    logic                trig_prev;
    logic                trig_rise;
    logic                accept;
    logic [TRIG_BIT-1:0] trig_num;

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            trig_sync <= '0;
            trig_prev <= 1'b0;
        end else begin
            trig_sync <= {trig_sync[0], trig_in};
            trig_prev <= trig_sync[1];
        end
    end

    assign trig_rise = trig_sync[1] && !trig_prev;
    assign accept    = trig_rise && trig_en && !veto && !fifo_full;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept)
                    state_nxt = WRITE_WORD;
            end
            WRITE_WORD: state_nxt = CMD_REQ;
            CMD_REQ: begin
                if (cmd_ack)
                    state_nxt = CMD_RELEASE;
            end
            CMD_RELEASE: begin
                // Sequencer done once ack drops
                if (!cmd_ack)
                    state_nxt = fifo_empty ? IDLE : HOLD_DRAIN;
            end
            HOLD_DRAIN: begin
                // Not busy here, so a new trigger is taken as in IDLE
                if (accept)
                    state_nxt = WRITE_WORD;
                else if (fifo_empty)
                    state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            trig_num <= '0;
        end else begin
            state <= state_nxt;
            if (state == WRITE_WORD)
                trig_num <= trig_num + 1'b1;  // Next trigger number
        end
    end

    assign wr      = (state == WRITE_WORD);
    assign word    = {1'b1, trig_num};    // TRIG_BIT marks a trigger word
    assign cmd_req = (state == CMD_REQ);
    assign busy    = (state == WRITE_WORD) || (state == CMD_REQ) ||
                     (state == CMD_RELEASE);
    assign hold    = (state != IDLE);     // Priority until words drained

endmodule

/* tdc_meas.sv */
////////////////////////////////////////////////////////////////////////////
// Pulse-width TDC
// Counts the high time of tdc_in and emits one numbered word per pulse
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tdc_meas import readout_pkg::*; (
    input  logic              bus_clk,
    input  logic              rst_n,
    input  logic              tdc_in,
    input  logic              fifo_full,
    output logic              wr,
    output logic [WORD_W-1:0] word,
    output logic              tdc_overflow
);

    logic                 tdc_prev;
    logic                 tdc_fall;
    logic [TDC_W-1:0]     width_cnt;
    logic [TDC_CNT_W-1:0] evt_cnt;
    logic                 wr_q;
    tdc_word_t            word_q;

    assign tdc_fall = tdc_prev && !tdc_in;

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            tdc_prev     <= 1'b0;
            width_cnt    <= '0;
            evt_cnt      <= '0;
            wr_q         <= 1'b0;
            tdc_overflow <= 1'b0;
        end else begin
            tdc_prev <= tdc_in;
            wr_q     <= tdc_fall;
            if (tdc_fall) begin
                width_cnt <= '0;
                evt_cnt   <= evt_cnt + 1'b1;  // Counts lost pulses too
            end else if (tdc_in && width_cnt != '1) begin
                width_cnt <= width_cnt + 1'b1;  // Saturating
            end
            if (wr_q && fifo_full)
                tdc_overflow <= 1'b1;     // Sticky until reset
        end
    end

    always_ff @(posedge bus_clk) begin
        if (tdc_fall) begin
            word_q.id      <= TDC_ID;
            word_q.evt_cnt <= evt_cnt;
            word_q.width   <= width_cnt;
        end
    end

    assign wr   = wr_q;     // FIFO drops it when full
    assign word = word_q;

endmodule

/* fe_rx_port.sv */
////////////////////////////////////////////////////////////////////////////
// Front-end word port
// Slave side of the fe_req/fe_ack handshake, tags words with FE_ID
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fe_rx_port import readout_pkg::*; (
    input  logic              bus_clk,
    input  logic              rst_n,
    input  logic              fe_req,
    input  logic [FE_W-1:0]   fe_data,
    output logic              fe_ack,
    input  logic              fifo_full,
    output logic              wr,
    output logic [WORD_W-1:0] word
);

    logic     take;
    logic     wr_q;
    fe_word_t word_q;

    // New request, ack still low, room in the FIFO
    assign take = fe_req && !fe_ack && !fifo_full;

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            fe_ack <= 1'b0;
            wr_q   <= 1'b0;
        end else begin
            wr_q <= take;
            if (take)
                fe_ack <= 1'b1;
            else if (!fe_req)
                fe_ack <= 1'b0;   // Return to zero
        end
    end

    always_ff @(posedge bus_clk) begin
        if (take) begin
            word_q.id      <= FE_ID;
            word_q.rsvd    <= '0;
            word_q.payload <= fe_data;
        end
    end

    assign wr   = wr_q;
    assign word = word_q;

endmodule

/* rr_arbiter.sv */
////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter
// Moves one source word per cycle to the output FIFO, a holding source
// takes priority
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rr_arbiter import readout_pkg::*; (
    input  logic                           bus_clk,
    input  logic                           rst_n,
    input  src_req_t [SRC_N-1:0]           req,
    input  logic [SRC_N-1:0][WORD_W-1:0]   din,
    output logic [SRC_N-1:0]               read_grant,
    input  logic                           out_near_full,
    output logic                           wr,
    output logic [WORD_W-1:0]              dout
);

    src_sel_t last_sel;
    src_sel_t sel;
    logic     found;

    function automatic src_sel_t step_src(src_sel_t s, int n);
        int k;
        k = (int'(s) + n) % SRC_N;
        return src_sel_t'(k[1:0]);
    endfunction

    always_comb begin
        sel   = last_sel;
        found = 1'b0;
        if (!out_near_full) begin   // In-flight word must still fit
            if (req[SRC_TLU].hold && req[SRC_TLU].not_empty) begin
                sel   = SRC_TLU;
                found = 1'b1;
            end else begin
                // Search starts after the last winner
                for (int i = 1; i <= SRC_N; i++) begin
                    if (!found && req[step_src(last_sel, i)].not_empty) begin
                        sel   = step_src(last_sel, i);
                        found = 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        read_grant = '0;
        if (found)
            read_grant[sel] = 1'b1;
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            last_sel <= SRC_FE;     // First search begins at TLU
            wr       <= 1'b0;
        end else begin
            wr <= found;
            if (found)
                last_sel <= sel;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (found)
            dout <= din[sel];
    end

endmodule

/* readout_top.sv */
////////////////////////////////////////////////////////////////////////////
// Readout top level
// Trigger, TDC and front-end sources merged into one host output buffer
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module readout_top import readout_pkg::*; (
    input  logic              bus_clk,
    input  logic              rst_n,
    input  logic              trig_en,
    input  logic              trig_in,
    input  logic              tdc_in,
    input  logic              fe_req,
    input  logic [FE_W-1:0]   fe_data,
    output logic              fe_ack,
    output logic              cmd_req,
    input  logic              cmd_ack,
    output logic              busy,
    output logic              tdc_overflow,
    input  logic              out_read,
    output logic              out_valid,
    output logic [WORD_W-1:0] out_data,
    output logic              out_full,
    output logic              out_near_full
);

    logic [SRC_N-1:0]             src_wr;
    logic [SRC_N-1:0][WORD_W-1:0] src_word;
    logic [SRC_N-1:0]             src_full;
    logic [SRC_N-1:0]             src_empty;
    logic [SRC_N-1:0][WORD_W-1:0] src_dout;
    logic [SRC_N-1:0]             read_grant;
    src_req_t [SRC_N-1:0]         src_req;
    logic                         tlu_hold;
    logic                         arb_wr;
    logic [WORD_W-1:0]            arb_dout;
    logic                         out_empty;

    assign src_req[SRC_TLU] = '{not_empty: !src_empty[SRC_TLU], hold: tlu_hold};
    assign src_req[SRC_TDC] = '{not_empty: !src_empty[SRC_TDC], hold: 1'b0};
    assign src_req[SRC_FE]  = '{not_empty: !src_empty[SRC_FE],  hold: 1'b0};
    assign out_valid        = !out_empty;

    tlu_ctrl tlu_ctrl0 (
        .bus_clk, .rst_n, .trig_en, .trig_in,
        .veto       (out_full),           // Output buffer full blocks triggers
        .fifo_full  (src_full[SRC_TLU]),
        .fifo_empty (src_empty[SRC_TLU]),
        .wr         (src_wr[SRC_TLU]),
        .word       (src_word[SRC_TLU]),
        .hold       (tlu_hold),
        .busy, .cmd_req, .cmd_ack
    );

    tdc_meas tdc_meas0 (
        .bus_clk, .rst_n, .tdc_in,
        .fifo_full (src_full[SRC_TDC]),
        .wr        (src_wr[SRC_TDC]),
        .word      (src_word[SRC_TDC]),
        .tdc_overflow
    );

    fe_rx_port fe_rx_port0 (
        .bus_clk, .rst_n, .fe_req, .fe_data, .fe_ack,
        .fifo_full (src_full[SRC_FE]),
        .wr        (src_wr[SRC_FE]),
        .word      (src_word[SRC_FE])
    );

    // One source FIFO per arbiter input
    for (genvar i = 0; i < SRC_N; i++) begin : g_src_fifo
        word_fifo #(.DEPTH(SRC_DEPTH)) src_fifo (
            .bus_clk, .rst_n,
            .wr        (src_wr[i]),
            .din       (src_word[i]),
            .rd        (read_grant[i]),
            .dout      (src_dout[i]),
            .empty     (src_empty[i]),
            .full      (src_full[i]),
            .near_full ()
        );
    end

    rr_arbiter rr_arbiter0 (
        .bus_clk, .rst_n,
        .req        (src_req),
        .din        (src_dout),
        .read_grant (read_grant),
        .out_near_full,
        .wr         (arb_wr),
        .dout       (arb_dout)
    );

    word_fifo #(.DEPTH(OUT_DEPTH)) out_fifo (
        .bus_clk, .rst_n,
        .wr        (arb_wr),
        .din       (arb_dout),
        .rd        (out_read),
        .dout      (out_data),
        .empty     (out_empty),
        .full      (out_full),
        .near_full (out_near_full)
    );

endmodule

/* readout_sva.sv */
////////////////////////////////////////////////////////////////////////////
// Readout checkers
// Grant and command handshake checks, bound into rr_arbiter and tlu_ctrl
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module readout_sva import readout_pkg::*; (
    input logic             bus_clk,
    input logic             rst_n,
    input logic [SRC_N-1:0] grant,
    input logic             near_full,
    input logic             cmd_req,
    input logic             cmd_ack,
    input logic             busy
);

    logic fail_seen = 1'b0;     // Any failed check

    grant_onehot: assert property (@(posedge bus_clk) disable iff (!rst_n)
        $onehot0(grant))
        else begin
            $error("read_grant has more than one bit set");
            fail_seen = 1'b1;
        end

    // Four-phase rule, request held until acknowledged
    req_held: assert property (@(posedge bus_clk) disable iff (!rst_n)
        cmd_req && !cmd_ack |=> cmd_req)
        else begin
            $error("cmd_req fell before cmd_ack rose");
            fail_seen = 1'b1;
        end

    busy_in_cmd: assert property (@(posedge bus_clk) disable iff (!rst_n)
        cmd_req |-> busy)
        else begin
            $error("busy low while cmd_req high");
            fail_seen = 1'b1;
        end

    no_grant_nf: assert property (@(posedge bus_clk) disable iff (!rst_n)
        near_full |-> grant == '0)
        else begin
            $error("grant given while the output FIFO is near full");
            fail_seen = 1'b1;
        end

endmodule

bind rr_arbiter readout_sva arb_chk (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .grant     (read_grant),
    .near_full (out_near_full),
    .cmd_req   (1'b0),
    .cmd_ack   (1'b0),
    .busy      (1'b0)
);

bind tlu_ctrl readout_sva tlu_chk (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .grant     ('0),
    .near_full (1'b0),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .busy      (busy)
);

/* tb_readout.sv */
////////////////////////////////////////////////////////////////////////////
// Readout testbench
// Random triggers, TDC pulses and front-end words against a reference
// model, with host back-pressure phases
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_readout import readout_pkg::*; ();

    localparam int FE_TIMEOUT    = 20000;
    localparam int WAIT_TIMEOUT  = 20000;
    localparam int DRAIN_TIMEOUT = 40000;
    localparam int TDC_MAX       = (1 << TDC_W) - 1;

    logic              bus_clk = 1'b0;
    logic              rst_n;
    logic              trig_en;
    logic              trig_in;
    logic              tdc_in;
    logic              fe_req;
    logic [FE_W-1:0]   fe_data;
    logic              fe_ack;
    logic              cmd_req;
    logic              cmd_ack;
    logic              busy;
    logic              tdc_overflow;
    logic              out_read;
    logic              out_valid;
    logic [WORD_W-1:0] out_data;
    logic              out_full;
    logic              out_near_full;

    // Reference model
    logic [FE_W-1:0]   fe_q[$];
    int                tdc_cnt_q[$];
    int                tdc_width_q[$];
    int                exp_trig   = 0;
    int                trig_words = 0;
    int                trig_sent  = 0;
    int                cmd_starts = 0;
    int                hs_done    = 0;
    int                stim_done  = 0;
    int                resp_state = 0;
    int                read_duty  = 70;   // Percent of cycles with out_read
    logic              run_stim   = 1'b0;
    logic              host_stall = 1'b0;
    logic              sva_fail;

    assign sva_fail = dut0.rr_arbiter0.arb_chk.fail_seen ||
                      dut0.tlu_ctrl0.tlu_chk.fail_seen;

    always #2 bus_clk = ~bus_clk;

    readout_top dut0 (.*);

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_tdc(input tdc_word_t tw);
        // Lost words leave a gap in the event counts
        while (tdc_cnt_q.size() > 0 && TDC_CNT_W'(tdc_cnt_q[0]) != tw.evt_cnt) begin
            assert (tdc_overflow)
                else fail_now($sformatf("Fail %0t: TDC count %0d skipped without overflow",
                                        $time, tdc_cnt_q[0]));
            void'(tdc_cnt_q.pop_front());
            void'(tdc_width_q.pop_front());
        end
        assert (tdc_cnt_q.size() > 0)
            else fail_now("A TDC word arrived with an event count that was never produced");
        assert (tw.width == TDC_W'(tdc_width_q[0]))
            else fail_now($sformatf("Fail %0t: TDC width %0d, expected %0d",
                                    $time, tw.width, tdc_width_q[0]));
        void'(tdc_cnt_q.pop_front());
        void'(tdc_width_q.pop_front());
    endtask

    // Sort a host word by its identifier
    task automatic check_word(input logic [WORD_W-1:0] w);
        tdc_word_t tw;
        fe_word_t  fw;
        tw = w;
        fw = w;
        if (w[TRIG_BIT]) begin
            assert (w[TRIG_BIT-1:0] == TRIG_BIT'(exp_trig))
                else fail_now($sformatf("Fail %0t: trigger number %0d, expected %0d",
                                        $time, w[TRIG_BIT-1:0], exp_trig));
            exp_trig++;
            trig_words++;
        end else if (fw.id == FE_ID) begin
            assert (fe_q.size() > 0)
                else fail_now("An FE word arrived that was never sent");
            assert (fw.rsvd == 4'd0 && fw.payload == fe_q[0])
                else fail_now($sformatf("Fail %0t: FE word %h, expected payload %h",
                                        $time, w, fe_q[0]));
            void'(fe_q.pop_front());
        end else begin
            assert (tw.id == TDC_ID)
                else fail_now($sformatf("Fail %0t: unknown identifier in word %h", $time, w));
            check_tdc(tw);
        end
    endtask

    task automatic drive_triggers();
        while (run_stim) begin
            @(posedge bus_clk);
            trig_in <= 1'b1;
            trig_sent++;
            repeat ($urandom_range(3, 1)) @(posedge bus_clk);
            trig_in <= 1'b0;
            // Gap longer than one full command handshake
            repeat ($urandom_range(80, 30)) @(posedge bus_clk);
        end
        stim_done++;
    endtask

    task automatic drive_tdc();
        int w;
        int evt;
        evt = 0;
        while (run_stim) begin
            if (evt == 0)
                w = 4200;   // Saturates the width field
            else if ($urandom_range(7, 0) == 0)
                w = $urandom_range(5000, 1);
            else
                w = $urandom_range(40, 1);
            @(posedge bus_clk);
            tdc_in <= 1'b1;
            repeat (w) @(posedge bus_clk);
            tdc_in <= 1'b0;
            tdc_cnt_q.push_back(evt);
            tdc_width_q.push_back((w > TDC_MAX) ? TDC_MAX : w);
            evt++;
            repeat ($urandom_range(20, 1)) @(posedge bus_clk);
        end
        stim_done++;
    endtask

    // Four-phase master on fe_req/fe_ack
    task automatic drive_fe();
        logic [FE_W-1:0] d;
        int              n;
        while (run_stim) begin
            d = FE_W'($urandom);
            @(posedge bus_clk);
            fe_data <= d;
            fe_req  <= 1'b1;
            fe_q.push_back(d);
            n = 0;
            @(posedge bus_clk);
            while (!fe_ack && n < FE_TIMEOUT) begin
                @(posedge bus_clk);
                n++;
            end
            assert (fe_ack) else fail_now("fe_ack was never raised for a pending fe_req");
            fe_req <= 1'b0;
            n = 0;
            @(posedge bus_clk);
            while (fe_ack && n < FE_TIMEOUT) begin
                @(posedge bus_clk);
                n++;
            end
            assert (!fe_ack) else fail_now("fe_ack did not return low after fe_req fell");
            repeat ($urandom_range(12, 0)) @(posedge bus_clk);
        end
        stim_done++;
    endtask

    // Host reader
    initial begin
        out_read = 1'b0;
        forever begin
            @(posedge bus_clk);
            // Grants stop at near-full, so the buffer never fills
            assert (!out_full)
                else fail_now($sformatf("Fail %0t: output buffer ran full", $time));
            if (out_read && out_valid)
                check_word(out_data);
            if (host_stall || !rst_n)
                out_read <= 1'b0;
            else
                out_read <= ($urandom_range(99, 0) < read_duty);
        end
    end

    // Command sequencer responder
    initial begin
        int dly;
        int n;
        cmd_ack = 1'b0;
        dly     = 0;
        n       = 0;
        forever begin
            @(posedge bus_clk);
            case (resp_state)
                0: begin
                    if (cmd_req) begin
                        assert (busy)
                            else fail_now($sformatf("Fail %0t: busy low at cmd_req", $time));
                        cmd_starts++;
                        dly        = $urandom_range(7, 0);
                        resp_state = 1;
                    end
                end
                1: begin
                    assert (busy && cmd_req)
                        else fail_now($sformatf("Fail %0t: busy or cmd_req dropped early",
                                                $time));
                    if (dly == 0) begin
                        cmd_ack    <= 1'b1;
                        n          = 0;
                        resp_state = 2;
                    end else begin
                        dly--;
                    end
                end
                2: begin
                    if (!cmd_req) begin
                        dly        = $urandom_range(7, 0);
                        resp_state = 3;
                    end else begin
                        n++;
                        assert (n < WAIT_TIMEOUT)
                            else fail_now("cmd_req stayed high after cmd_ack rose");
                    end
                end
                default: begin
                    assert (busy)
                        else fail_now($sformatf("Fail %0t: busy low before cmd_ack fell",
                                                $time));
                    if (dly == 0) begin
                        cmd_ack    <= 1'b0;
                        hs_done++;
                        resp_state = 0;
                    end else begin
                        dly--;
                    end
                end
            endcase
        end
    end

    always @(posedge bus_clk) begin
        assert (!sva_fail) else fail_now("A bound assertion on the arbiter or trigger failed");
    end

    initial begin
        int c0;
        int t0;
        int n;
        int quiet;
        void'($urandom(30828));
        rst_n   = 1'b0;
        trig_en = 1'b1;
        trig_in = 1'b0;
        tdc_in  = 1'b0;
        fe_req  = 1'b0;
        fe_data = '0;
        repeat (5) @(posedge bus_clk);
        rst_n <= 1'b1;
        @(posedge bus_clk);
        assert (!out_valid && !busy && !cmd_req && !fe_ack && !tdc_overflow)
            else fail_now($sformatf("Fail %0t: outputs not low after reset", $time));

        run_stim = 1'b1;
        fork
            drive_triggers();
            drive_tdc();
            drive_fe();
        join_none
        repeat (3000) @(posedge bus_clk);

        // Host stall, buffers fill up
        host_stall = 1'b1;
        n = 0;
        while (!out_near_full && n < WAIT_TIMEOUT) begin
            @(posedge bus_clk);
            n++;
        end
        assert (out_near_full) else fail_now("out_near_full never rose while the host stalled");
        c0 = cmd_starts;
        t0 = trig_sent;
        n  = 0;
        while (trig_sent < t0 + SRC_DEPTH + 2 && n < WAIT_TIMEOUT) begin
            @(posedge bus_clk);
            n++;
        end
        assert (n < WAIT_TIMEOUT) else fail_now("Trigger edges stopped during the stall");
        assert (cmd_starts - c0 <= SRC_DEPTH)
            else fail_now($sformatf("Fail %0t: %0d triggers accepted into a blocked buffer",
                                    $time, cmd_starts - c0));
        c0 = cmd_starts;
        t0 = trig_sent;
        n  = 0;
        while (trig_sent < t0 + 3 && n < WAIT_TIMEOUT) begin
            @(posedge bus_clk);
            n++;
        end
        repeat (20) @(posedge bus_clk);
        assert (cmd_starts == c0)
            else fail_now($sformatf("Fail %0t: cmd_req rose while the buffer was full", $time));

        // Drain, triggers must be accepted again
        host_stall = 1'b0;
        read_duty  = 30;
        c0 = cmd_starts;
        n  = 0;
        while (cmd_starts == c0 && n < WAIT_TIMEOUT) begin
            @(posedge bus_clk);
            n++;
        end
        assert (cmd_starts > c0) else fail_now("No trigger was accepted after the stall ended");
        repeat (3000) @(posedge bus_clk);

        run_stim  = 1'b0;
        read_duty = 90;
        n = 0;
        while ((stim_done < 3 || resp_state != 0) && n < WAIT_TIMEOUT) begin
            @(posedge bus_clk);
            n++;
        end
        assert (n < WAIT_TIMEOUT) else fail_now("Stimulus processes did not finish");
        quiet = 0;
        n     = 0;
        while (quiet < 40 && n < DRAIN_TIMEOUT) begin
            @(posedge bus_clk);
            n++;
            quiet = out_valid ? 0 : quiet + 1;
        end
        assert (quiet >= 40) else fail_now("The host port did not drain");
        assert (!out_valid && fe_q.size() == 0 && tdc_cnt_q.size() == 0)
            else fail_now($sformatf("Fail %0t: %0d FE and %0d TDC words still expected",
                                    $time, fe_q.size(), tdc_cnt_q.size()));
        assert (trig_words == hs_done && trig_words > 0)
            else fail_now($sformatf("Fail %0t: %0d trigger words for %0d handshakes",
                                    $time, trig_words, hs_done));

        if (!sva_fail) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_now("A bound assertion reported a failure");
        end
    end

endmodule

/* build.f */
readout_pkg.sv
word_fifo.sv
tlu_ctrl.sv
tdc_meas.sv
fe_rx_port.sv
rr_arbiter.sv
readout_top.sv
readout_sva.sv
tb_readout.sv

/* Makefile */
# Verilator build and run of the readout testbench
VERILATOR ?= verilator
TOP       ?= tb_readout
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= TESTBENCH FAILED
PASS_MSG  ?= TESTBENCH PASSED

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)

check: run
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
